// File: Makefile
# Verilator flow for the subbytes engine testbench

TOP := tb_aes_sub

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing -f tb.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

// File: tb.f
+incdir+verilog
verilog/aes_sub_pkg.sv
verilog/tr_in.sv
verilog/gf16_inv.sv
verilog/tr_out.sv
verilog/sbox_lane.sv
verilog/wb_sub_port.sv
verilog/result_collector.sv
verilog/aes_sub_top.sv
testbench/tb_aes_sub.sv

// File: testbench/sub_tests.txt
# op dir in_word expected_word, dir 1 forward sbox, 0 inverse sbox
# op S single, B group of 4 back to back, O group of 5 with stall, R random round trip
S 1 00010203 637C777B
S 1 5363C000 EDFBBA63
S 1 FFAA5510 16ACFCCA
S 0 637C777B 00010203
S 0 EDFBBA63 5363C000
S 0 16ACFCCA FFAA5510
S 0 8C01D4C9 F0091912
B 1 0A0B0C0D 672BFED7
B 0 672BFED7 0A0B0C0D
B 1 80818283 CD0C13EC
B 1 DEADBEEF 1D95AEDF
O 1 11223344 8293C31B
O 1 55667788 FC33F5C4
O 0 8293C31B 11223344
O 1 99AABBCC EEACEA4B
O 0 FC33F5C4 55667788
R 1 00000000 00000000
R 1 00000000 00000000
R 1 00000000 00000000

// File: testbench/tb_aes_sub.sv
// testbench for the subbytes engine that runs the test table over the wishbone port
`timescale 1ns/1ps
`default_nettype none

`include "aes_sub_settings.svh"

module tb_aes_sub import aes_sub_pkg::*; ();

    logic                      clk = 1'b0;
    logic                      arst_n = 1'b0;
    logic                      wb_cyc = 1'b0;
    logic                      wb_stb = 1'b0;
    logic                      wb_we = 1'b0;
    logic [`AES_SUB_ADR_W-1:0] wb_adr = '0;
    bus_word_t                 wb_dat_w = '0;
    bus_word_t                 wb_dat_r;
    logic                      wb_ack;

    logic [7:0] op_q [$];   // test table with one entry per file line
    logic       dir_q [$];  // 1 forward, 0 inverse
    bus_word_t  in_q [$];
    bus_word_t  exp_q [$];
    int         n_tests = 0;
    int         seed;

    aes_sub_top i_dut (
        .clk(clk), .arst_n(arst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    always #50 clk = ~clk;  // 100 ns period

    // ---------------------------------------------------------------------------
    // reporting and checking
    // ---------------------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input bus_word_t got, input bus_word_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s is %08h, expected %08h", $time, name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    // ---------------------------------------------------------------------------
    // wishbone classic master
    // ---------------------------------------------------------------------------
    task automatic wait_ack();
        do @(negedge clk); while (!wb_ack);  // ack is stable mid cycle
    endtask

    task automatic bus_write(input logic [`AES_SUB_ADR_W-1:0] adr, input bus_word_t data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        wait_ack();
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_read(input logic [`AES_SUB_ADR_W-1:0] adr, output bus_word_t data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        wait_ack();
        data = wb_dat_r;  // registered with ack
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    // write that must stall and is dropped again after the given cycles
    task automatic write_stalled(input logic [`AES_SUB_ADR_W-1:0] adr, input bus_word_t data,
                                 input int cycles);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        repeat (cycles) begin
            @(negedge clk);
            check_value("wb_ack", {31'b0, wb_ack}, 32'd0);
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    // poll status until the fifo holds n words
    task automatic wait_level(input int n);
        bus_word_t lvl;
        do bus_read(`AES_SUB_ADR_STAT, lvl); while (lvl != bus_word_t'(n));
    endtask

    function automatic logic [`AES_SUB_ADR_W-1:0] issue_adr(input logic fwd);
        return fwd ? `AES_SUB_ADR_FWD : `AES_SUB_ADR_INV;
    endfunction

    // ---------------------------------------------------------------------------
    // test kinds
    // ---------------------------------------------------------------------------
    task automatic single_word(input int i);
        bus_word_t got;
        bus_write(issue_adr(dir_q[i]), in_q[i]);
        wait_level(1);
        bus_read(`AES_SUB_ADR_DOUT, got);
        check_value("wb_dat_r", got, exp_q[i]);
    endtask

    task automatic burst_in_order(input int i);
        bus_word_t got;
        for (int k = 0; k < 4; k++) bus_write(issue_adr(dir_q[i+k]), in_q[i+k]);
        wait_level(4);
        for (int k = 0; k < 4; k++) begin
            bus_read(`AES_SUB_ADR_DOUT, got);
            check_value("wb_dat_r", got, exp_q[i+k]);  // issue order
        end
    endtask

    task automatic overflow_stall(input int i);
        bus_word_t got;
        for (int k = 0; k < 4; k++) bus_write(issue_adr(dir_q[i+k]), in_q[i+k]);
        wait_level(4);
        write_stalled(issue_adr(dir_q[i+4]), in_q[i+4], 20);  // fifo full
        bus_read(`AES_SUB_ADR_DOUT, got);
        check_value("wb_dat_r", got, exp_q[i]);
        bus_write(issue_adr(dir_q[i+4]), in_q[i+4]);  // now a slot is free
        wait_level(4);
        for (int k = 1; k < 5; k++) begin
            bus_read(`AES_SUB_ADR_DOUT, got);
            check_value("wb_dat_r", got, exp_q[i+k]);
        end
    endtask

    task automatic round_trip();
        bus_word_t orig;
        bus_word_t mid;
        bus_word_t back;
        orig = $random(seed);
        bus_write(`AES_SUB_ADR_FWD, orig);
        wait_level(1);
        bus_read(`AES_SUB_ADR_DOUT, mid);
        bus_write(`AES_SUB_ADR_INV, mid);  // inverse must undo forward
        wait_level(1);
        bus_read(`AES_SUB_ADR_DOUT, back);
        check_value("round trip word", back, orig);
    endtask

    // ---------------------------------------------------------------------------
    // file, watchdog, main sequence
    // ---------------------------------------------------------------------------
    task automatic load_tests();
        int         fd;
        string      line;
        logic [7:0] op;
        bus_word_t  d, w, e;
        fd = $fopen("testbench/sub_tests.txt", "r");
        if (fd == 0) abort_run("could not open testbench/sub_tests.txt");
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 4 || line.getc(0) == "#") continue;  // comment or blank
            if ($sscanf(line, "%c %h %h %h", op, d, w, e) != 4)
                abort_run("malformed line in test file");
            op_q.push_back(op);
            dir_q.push_back(d[0]);
            in_q.push_back(w);
            exp_q.push_back(e);
        end
        $fclose(fd);
        n_tests = op_q.size();
        if (n_tests == 0) abort_run("test file holds no tests");
    endtask

    // scaled to the table length
    initial begin
        wait (n_tests != 0);
        repeat (n_tests * 200) @(posedge clk);
        abort_run("timeout, the run did not finish in time");
    end

    initial begin
        bus_word_t v;
        int        i;
        seed = 32'h1199_f598;
        load_tests();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        // empty fifo reads and an ignored write to status
        bus_read(`AES_SUB_ADR_STAT, v);
        check_value("status", v, 32'd0);
        bus_read(`AES_SUB_ADR_DOUT, v);
        check_value("wb_dat_r", v, 32'd0);
        bus_write(`AES_SUB_ADR_STAT, 32'h0000_00ff);
        repeat (3) @(posedge clk);  // a stray result would land 3 cycles after ack
        bus_read(`AES_SUB_ADR_STAT, v);
        check_value("status", v, 32'd0);

        i = 0;
        while (i < n_tests) begin
            case (op_q[i])
                "S": begin
                    single_word(i);
                    i += 1;
                end
                "R": begin
                    round_trip();
                    i += 1;
                end
                "B": begin
                    if (i + 4 > n_tests) abort_run("burst group in test file is short");
                    burst_in_order(i);
                    i += 4;
                end
                "O": begin
                    if (i + 5 > n_tests) abort_run("overflow group in test file is short");
                    overflow_stall(i);
                    i += 5;
                end
                default: abort_run("unknown opcode in test file");
            endcase
        end

        bus_read(`AES_SUB_ADR_STAT, v);
        check_value("status", v, 32'd0);  // nothing left behind
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/aes_sub_pkg.sv
// common types for the sbox engine, imported by every rtl module that needs them
`default_nettype none

`include "aes_sub_settings.svh"

package aes_sub_pkg;

    // ---------------------------------------------------------------------------
    // field and bus vectors
    // ---------------------------------------------------------------------------
    typedef logic [7:0]  gf256_t;    // byte in polynomial basis
    typedef logic [3:0]  gf16_t;     // nibble of the composite field
    typedef logic [31:0] bus_word_t; // wishbone data

    // occupancy 0..depth inclusive
    typedef logic [$clog2(`AES_SUB_FIFO_DEPTH + 1) - 1:0] fifo_cnt_t;

    // register decode
    typedef enum logic [`AES_SUB_ADR_W - 1:0] {
        SEL_FWD  = `AES_SUB_ADR_FWD,
        SEL_INV  = `AES_SUB_ADR_INV,
        SEL_DOUT = `AES_SUB_ADR_DOUT,
        SEL_STAT = `AES_SUB_ADR_STAT
    } reg_sel_e;

endpackage

`default_nettype wire

// File: verilog/aes_sub_settings.svh
// shared widths, depths and register map for the sbox engine, included by rtl and testbench
`ifndef AES_SUB_SETTINGS_SVH
`define AES_SUB_SETTINGS_SVH

// ---------------------------------------------------------------------------
// datapath shape
// ---------------------------------------------------------------------------
`define AES_SUB_LANES       4   // byte lanes per bus word
`define AES_SUB_FIFO_DEPTH  4   // result fifo entries

// ---------------------------------------------------------------------------
// register map, word addresses
// ---------------------------------------------------------------------------
`define AES_SUB_ADR_W       2   // decoded word address bits

`define AES_SUB_ADR_FWD     2'd0  // write: forward subbytes
`define AES_SUB_ADR_INV     2'd1  // write: inverse subbytes
`define AES_SUB_ADR_DOUT    2'd2  // read: fifo head, pops
`define AES_SUB_ADR_STAT    2'd3  // read: fifo fill level

`endif

// File: verilog/aes_sub_top.sv
// top of the memory mapped subbytes engine: bus port, four sbox lanes, result fifo
`timescale 1ns/1ps
`default_nettype none

`include "aes_sub_settings.svh"

module aes_sub_top import aes_sub_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`AES_SUB_ADR_W-1:0] wb_adr,
    input  bus_word_t                 wb_dat_w,
    output bus_word_t                 wb_dat_r,
    output logic                      wb_ack
);

    bus_word_t issue_word;
    logic      in_encrypt;
    logic      issue, pop;
    bus_word_t head_word;
    fifo_cnt_t count;
    logic      issue_ok;
    gf256_t    lane_out   [`AES_SUB_LANES];
    logic      lane_valid [`AES_SUB_LANES];

    wb_sub_port i_port (
        .clk(clk), .arst_n(arst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .issue_word(issue_word), .in_encrypt(in_encrypt),
        .issue(issue), .pop(pop),
        .head_word(head_word), .count(count), .issue_ok(issue_ok)
    );

    // ---------------------------------------------------------------------------
    // byte lanes, issue pulse doubles as lane valid
    // ---------------------------------------------------------------------------
    for (genvar i = 0; i < `AES_SUB_LANES; i++) begin : g_lane
        sbox_lane i_lane (
            .clk(clk), .arst_n(arst_n),
            .in_byte(issue_word[8*i +: 8]), .in_encrypt(in_encrypt), .in_valid(issue),
            .out_byte(lane_out[i]), .out_valid(lane_valid[i])
        );
    end

    result_collector i_collect (
        .clk(clk), .arst_n(arst_n),
        .lane_bytes(lane_out), .lane_valid(lane_valid[0]),
        .issue(issue), .pop(pop),
        .head_word(head_word), .count(count), .issue_ok(issue_ok)
    );

endmodule

`default_nettype wire

// File: verilog/gf16_inv.sv
// inversion in GF((2^4)^2) via the norm nibble, zero maps to zero
`timescale 1ns/1ps
`default_nettype none

module gf16_inv import aes_sub_pkg::*; (
    input  gf16_t a,   // high nibble
    input  gf16_t b,   // low nibble
    output gf16_t ia,
    output gf16_t ib
);

    // GF(4) multiply, x^2+x+1
    function automatic logic [1:0] gf4_mul(input logic [1:0] q, input logic [1:0] w);
        return {(q[1] & w[1]) ^ (q[0] & w[1]) ^ (q[1] & w[0]),
                (q[1] & w[1]) ^ (q[0] & w[0])};
    endfunction

    // GF(16) as GF(4)^2 with phi = {10}
    function automatic gf16_t gf16_mul(input gf16_t q, input gf16_t w);
        logic [1:0] lo;
        logic [1:0] hh;
        lo = gf4_mul(q[1:0], w[1:0]);
        hh = gf4_mul(q[3:2], w[3:2]);
        return {gf4_mul(q[3:2] ^ q[1:0], w[3:2] ^ w[1:0]) ^ lo,
                {hh[1] ^ hh[0], hh[1]} ^ lo};  // hh*phi
    endfunction

    // x^2 then times lambda, folded
    function automatic gf16_t sq_lambda(input gf16_t q);
        gf16_t s;
        s = {q[3], q[3] ^ q[2], q[2] ^ q[1], q[3] ^ q[1] ^ q[0]};
        return {s[2] ^ s[0], s[3] ^ s[2] ^ s[1] ^ s[0], s[3], s[2]};
    endfunction

    // GF(16) inverse, direct sum of products
    function automatic gf16_t gf16_recip(input gf16_t q);
        gf16_t r;
        r[3] = q[3] ^ (q[3] & q[2] & q[1]) ^ (q[3] & q[0]) ^ q[2];
        r[2] = (q[3] & q[2] & q[1]) ^ (q[3] & q[2] & q[0]) ^ (q[3] & q[0]) ^ q[2]
             ^ (q[2] & q[1]);
        r[1] = q[3] ^ (q[3] & q[2] & q[1]) ^ (q[3] & q[1] & q[0]) ^ q[2]
             ^ (q[2] & q[0]) ^ q[1];
        r[0] = (q[3] & q[2] & q[1]) ^ (q[3] & q[2] & q[0]) ^ (q[3] & q[1])
             ^ (q[3] & q[1] & q[0]) ^ (q[3] & q[0]) ^ q[2] ^ (q[2] & q[1])
             ^ (q[2] & q[1] & q[0]) ^ q[1] ^ q[0];
        return r;
    endfunction

    gf16_t sum_ab;  // a + b
    gf16_t norm;    // a^2*lambda + (a+b)*b
    gf16_t norm_i;

    assign sum_ab = a ^ b;
    assign norm   = sq_lambda(a) ^ gf16_mul(sum_ab, b);
    assign norm_i = gf16_recip(norm);
    assign ia     = gf16_mul(a, norm_i);
    assign ib     = gf16_mul(sum_ab, norm_i);

endmodule

`default_nettype wire

// File: verilog/result_collector.sv
// result fifo of the sbox engine, packs lane bytes into words and tracks reserved slots
`timescale 1ns/1ps
`default_nettype none

`include "aes_sub_settings.svh"

module result_collector import aes_sub_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  gf256_t    lane_bytes [`AES_SUB_LANES],
    input  logic      lane_valid,  // lane 0 timing stands for all
    input  logic      issue,
    input  logic      pop,
    output bus_word_t head_word,
    output fifo_cnt_t count,
    output logic      issue_ok
);

    localparam int PTR_W = $clog2(`AES_SUB_FIFO_DEPTH);

    bus_word_t        mem [`AES_SUB_FIFO_DEPTH];  // circular store
    bus_word_t        push_word;
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    fifo_cnt_t        reserved;  // words issued, not yet landed
    logic [3:0]       committed;

    // lane 0 in the low byte
    always_comb begin
        for (int i = 0; i < `AES_SUB_LANES; i++) begin
            push_word[8*i +: 8] = lane_bytes[i];
        end
    end

    // include a pulse issued this very cycle
    assign committed = 4'(count) + 4'(reserved) + 4'(issue);
    assign issue_ok  = (committed < 4'(`AES_SUB_FIFO_DEPTH));
    assign head_word = mem[rd_ptr];

    // ---------------------------------------------------------------------------
    // pointers, fill level and credits
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            reserved <= '0;
        end else begin
            if (lane_valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop)        rd_ptr <= rd_ptr + 1'b1;
            case ({lane_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // push and pop together, level holds
            endcase
            case ({issue, lane_valid})
                2'b10:   reserved <= reserved + 1'b1;
                2'b01:   reserved <= reserved - 1'b1;  // result landed
                default: ;
            endcase
        end
    end

    // storage, credits keep it from overflowing
    always_ff @(posedge clk) begin
        if (lane_valid) mem[wr_ptr] <= push_word;
    end

endmodule

`default_nettype wire

// File: verilog/sbox_lane.sv
// one byte lane of the combined sbox, two register stages, accepts a byte every cycle
`timescale 1ns/1ps
`default_nettype none

module sbox_lane import aes_sub_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  gf256_t in_byte,
    input  logic   in_encrypt,
    input  logic   in_valid,
    output gf256_t out_byte,
    output logic   out_valid
);

    gf16_t a, b;     // composite field pair
    gf16_t ia, ib;   // inverted pair
    gf16_t ia_q, ib_q;
    logic  enc_q;    // direction travels with the data
    logic  vld_q;
    gf256_t s;

    tr_in i_tr_in (.g(in_byte), .encrypt(in_encrypt), .a(a), .b(b));

    gf16_inv i_inv (.a(a), .b(b), .ia(ia), .ib(ib));

    // ---------------------------------------------------------------------------
    // stage 1: inversion result
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        ia_q  <= ia;
        ib_q  <= ib;
        enc_q <= in_encrypt;
    end

    tr_out i_tr_out (.ia(ia_q), .ib(ib_q), .encrypt(enc_q), .s(s));

    // stage 2: lane output
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) out_valid <= 1'b0;
        else         out_valid <= vld_q;
    end

    always_ff @(posedge clk) begin
        out_byte <= s;  // payload, no reset
    end

endmodule

`default_nettype wire

// File: verilog/tr_in.sv
// input transform of the combined sbox, maps a byte into the composite field nibble pair
`timescale 1ns/1ps
`default_nettype none

module tr_in import aes_sub_pkg::*; (
    input  gf256_t g,
    input  logic   encrypt,  // 1: sbox, 0: inverse sbox
    output gf16_t  a,        // high nibble
    output gf16_t  b         // low nibble
);

    // polynomial basis -> GF(((2^2)^2)^2), isomorphism delta
    function automatic gf256_t iso_map(input gf256_t x);
        gf256_t q;
        q[7] = x[7] ^ x[5];
        q[6] = x[7] ^ x[6] ^ x[4] ^ x[3] ^ x[2] ^ x[1];
        q[5] = x[7] ^ x[5] ^ x[3] ^ x[2];
        q[4] = x[7] ^ x[5] ^ x[3] ^ x[2] ^ x[1];
        q[3] = x[7] ^ x[6] ^ x[2] ^ x[1];
        q[2] = x[7] ^ x[4] ^ x[3] ^ x[2] ^ x[1];
        q[1] = x[6] ^ x[4] ^ x[1];
        q[0] = x[6] ^ x[1] ^ x[0];
        return q;
    endfunction

    // undo the aes affine step, x_i = b_(i+2) ^ b_(i+5) ^ b_(i+7) ^ 05_i
    function automatic gf256_t inv_affine(input gf256_t y);
        gf256_t x;
        for (int i = 0; i < 8; i++) begin
            x[i] = y[(i + 2) % 8] ^ y[(i + 5) % 8] ^ y[(i + 7) % 8];
        end
        return x ^ 8'h05;
    endfunction

    // ---------------------------------------------------------------------------
    // two networks, kept in complemented form
    // ---------------------------------------------------------------------------
    gf256_t fwd_n;  // encrypt path
    gf256_t inv_n;  // decrypt path, affine undone first

    assign fwd_n = ~iso_map(g);
    assign inv_n = ~iso_map(inv_affine(g));

    // mux then invert back
    assign {a, b} = ~(encrypt ? fwd_n : inv_n);

endmodule

`default_nettype wire

// File: verilog/tr_out.sv
// output transform of the combined sbox, back to polynomial basis with affine on encrypt
`timescale 1ns/1ps
`default_nettype none

module tr_out import aes_sub_pkg::*; (
    input  gf16_t  ia,       // inverted high nibble
    input  gf16_t  ib,       // inverted low nibble
    input  logic   encrypt,
    output gf256_t s
);

    // composite field -> polynomial basis, inverse isomorphism
    function automatic gf256_t iso_unmap(input gf256_t x);
        gf256_t q;
        q[7] = x[7] ^ x[6] ^ x[5] ^ x[1];
        q[6] = x[6] ^ x[2];
        q[5] = x[6] ^ x[5] ^ x[1];
        q[4] = x[6] ^ x[5] ^ x[4] ^ x[2] ^ x[1];
        q[3] = x[5] ^ x[4] ^ x[3] ^ x[2] ^ x[1];
        q[2] = x[7] ^ x[4] ^ x[3] ^ x[2] ^ x[1];
        q[1] = x[5] ^ x[4];
        q[0] = x[6] ^ x[5] ^ x[4] ^ x[2] ^ x[0];
        return q;
    endfunction

    // aes affine: b_i = x_i ^ x_(i+4) ^ x_(i+5) ^ x_(i+6) ^ x_(i+7) ^ 63_i
    function automatic gf256_t affine(input gf256_t x);
        gf256_t y;
        for (int i = 0; i < 8; i++) begin
            y[i] = x[i] ^ x[(i + 4) % 8] ^ x[(i + 5) % 8] ^ x[(i + 6) % 8]
                 ^ x[(i + 7) % 8];
        end
        return y ^ 8'h63;
    endfunction

    // ---------------------------------------------------------------------------
    // basis change shared, affine only on the forward side
    // ---------------------------------------------------------------------------
    gf256_t poly;  // plain inverse in polynomial basis

    assign poly = iso_unmap({ia, ib});
    assign s    = encrypt ? affine(poly) : poly;

endmodule

`default_nettype wire

// File: verilog/wb_sub_port.sv
// wishbone classic slave of the sbox engine, issues words to the lanes and serves reads
`timescale 1ns/1ps
`default_nettype none

`include "aes_sub_settings.svh"

module wb_sub_port import aes_sub_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`AES_SUB_ADR_W-1:0] wb_adr,
    input  bus_word_t                 wb_dat_w,
    output bus_word_t                 wb_dat_r,
    output logic                      wb_ack,
    output bus_word_t                 issue_word,
    output logic                      in_encrypt,
    output logic                      issue,
    output logic                      pop,
    input  bus_word_t                 head_word,
    input  fifo_cnt_t                 count,
    input  logic                      issue_ok
);

    reg_sel_e sel;
    logic     req;       // live request, not yet acked
    logic     is_issue;  // write to fwd or inv
    logic     take;      // ack goes out next cycle
    logic     not_empty;

    assign sel       = reg_sel_e'(wb_adr);
    assign req       = wb_cyc & wb_stb & ~wb_ack;  // ack drops stb next cycle
    assign is_issue  = wb_we & (sel == SEL_FWD || sel == SEL_INV);
    assign take      = req & (~is_issue | issue_ok);  // stall issue writes on credit
    assign not_empty = (count != '0);

    // ---------------------------------------------------------------------------
    // ack, issue and pop strobes
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
            issue  <= 1'b0;
            pop    <= 1'b0;
        end else begin
            wb_ack <= take;
            issue  <= take & is_issue;
            pop    <= take & ~wb_we & (sel == SEL_DOUT) & not_empty;
        end
    end

    // issue word and direction, held for the lanes
    always_ff @(posedge clk) begin
        if (take && is_issue) begin
            issue_word <= wb_dat_w;
            in_encrypt <= (sel == SEL_FWD);
        end
    end

    // read data, other addresses read zero
    always_ff @(posedge clk) begin
        if (take && !wb_we) begin
            case (sel)
                SEL_DOUT: wb_dat_r <= not_empty ? head_word : '0;
                SEL_STAT: wb_dat_r <= bus_word_t'(count);  // zero extended
                default:  wb_dat_r <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire
